//--- flist.f
src/np_types_pkg.sv
src/np_reg_pkg.sv
src/dest_ip_filter.sv
src/flow_classifier.sv
src/ppu_packet_buffer.sv
src/out_arbiter.sv
src/np_core.sv
verification/np_core_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then judge the run from sim.log
verilator --binary --timing --assert -j 0 --top-module np_core_tb -f flist.f -o np_core_sim \
    && ./obj_dir/np_core_sim | tee sim.log \
    && ! grep -q "Checks failed" sim.log \
    && grep -q "All checks passed" sim.log \
    || { echo "simulation FAILED"; exit 1; }

//--- src/dest_ip_filter.sv
//==========================================================================
// snoops bus writes to fill a 16 entry ip table, never answers the bus
// writing zero to an entry frees it
//==========================================================================
`default_nettype none

module dest_ip_filter (
    input  logic                 clk,
    input  logic                 reset,
    input  np_reg_pkg::reg_bus_t reg_in,
    input  logic [31:0]          lookup_ip,
    output logic                 match
);
    import np_reg_pkg::*;

    localparam int IDX_W = $clog2(FILTER_ENTRIES);

    logic [REG_DATA_WIDTH-1:0] entry_ip [FILTER_ENTRIES];
    logic [FILTER_ENTRIES-1:0] entry_valid;
    logic [FILTER_ENTRIES-1:0] hit;
    logic                      wr_hit;
    logic [IDX_W-1:0]          wr_idx;

    // write strobe, window decoded on the upper address bits
    assign wr_hit = reg_in.req && !reg_in.rd_wr_l &&
                    (reg_in.addr[REG_ADDR_WIDTH-1:IDX_W] ==
                     FILTER_BASE[REG_ADDR_WIDTH-1:IDX_W]);
    assign wr_idx = reg_in.addr[IDX_W-1:0];

    // valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (wr_hit) begin
            entry_valid[wr_idx] <= (reg_in.data != '0);
        end
    end

    // ip storage
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            entry_ip[wr_idx] <= reg_in.data;
        end
    end

    // parallel compare, CAM style
    always_comb begin
        for (int i = 0; i < FILTER_ENTRIES; i++) begin
            hit[i] = entry_valid[i] && (entry_ip[i] == lookup_ip);
        end
    end
    assign match = |hit;

    // a write outside the window leaves the table alone
    a_write_in_window: assert property (@(posedge clk) disable iff (reset)
        (reg_in.req && !reg_in.rd_wr_l &&
         ((reg_in.addr < FILTER_BASE) ||
          (reg_in.addr >= FILTER_BASE + REG_ADDR_WIDTH'(FILTER_ENTRIES))))
        |=> $stable(entry_valid));

endmodule

`default_nettype wire

//--- src/flow_classifier.sv
//==========================================================================
// frames input packets, checks the destination ip, spreads over lanes
// a packet starts only on a lane with room for a full size packet
//==========================================================================
`default_nettype none

module flow_classifier (
    input  logic                                clk,
    input  logic                                reset,
    input  np_types_pkg::np_word_t              in_word,
    input  logic                                in_wr,
    output logic                                in_rdy,
    output logic [31:0]                         lookup_ip,
    input  logic                                match,
    input  logic [np_types_pkg::FREE_W-1:0]     free_words [np_types_pkg::NUM_LANES],
    output np_types_pkg::lane_wr_t              lane_wr [np_types_pkg::NUM_LANES]
);
    import np_types_pkg::*;

    localparam int WCNT_W = $clog2(MAX_PKT_WORDS);

    // framing state
    logic                 in_pkt;
    logic [WCNT_W-1:0]    wcnt;
    logic [LANE_W-1:0]    cur_lane;
    logic                 drop_q;

    logic [NUM_LANES-1:0] pend;
    logic [NUM_LANES-1:0] qual;
    logic [LANE_W-1:0]    pick;
    logic                 accept;
    logic                 last;
    logic                 drop_now;

    // staged lane write
    np_word_t             word_q;
    logic                 wr_q;
    logic                 commit_q;
    logic                 discard_q;
    logic [LANE_W-1:0]    tgt_q;

    //======================================================================
    // lane choice
    //======================================================================
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            // staged word not yet counted by the lane
            pend[i] = wr_q && (tgt_q == LANE_W'(i));
            qual[i] = free_words[i] >= FREE_W'(MAX_PKT_WORDS) + FREE_W'(pend[i]);
        end
    end

    assign pick     = rr_next(qual, cur_lane);
    // mid packet always ready, space was reserved at the header
    assign in_rdy   = in_pkt || (|qual);
    assign accept   = in_wr && in_rdy;
    assign last     = is_eop(in_word.ctrl);
    assign lookup_ip = in_word.data[31:0];
    // a 4 word packet ends on the ip word itself
    assign drop_now = (wcnt == WCNT_W'(DIP_WORD)) ? match : drop_q;

    //======================================================================
    // framing and staging
    //======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt    <= 1'b0;
            wcnt      <= '0;
            cur_lane  <= LANE_W'(NUM_LANES - 1);
            drop_q    <= 1'b0;
            wr_q      <= 1'b0;
            commit_q  <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            wr_q      <= accept;
            commit_q  <= accept && last && !drop_now;
            discard_q <= accept && last && drop_now;
            if (accept) begin
                if (!in_pkt) begin
                    cur_lane <= pick;
                end
                if (wcnt == WCNT_W'(DIP_WORD)) begin
                    drop_q <= match;
                end
                if (last) begin
                    in_pkt <= 1'b0;
                    wcnt   <= '0;
                end else begin
                    in_pkt <= 1'b1;
                    wcnt   <= wcnt + 1'b1;
                end
            end
        end
    end

    // word and target lane
    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= in_word;
            tgt_q  <= in_pkt ? cur_lane : pick;
        end
    end

    // fan out to lanes
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_wr[i].word    = word_q;
            lane_wr[i].wr      = pend[i];
            lane_wr[i].commit  = commit_q && pend[i];
            lane_wr[i].discard = discard_q && pend[i];
        end
    end

    // source honours in_rdy
    a_wr_needs_rdy: assert property (@(posedge clk) disable iff (reset)
        in_wr |-> in_rdy);

    // every packet opens with a header word
    a_hdr_first: assert property (@(posedge clk) disable iff (reset)
        (in_wr && !in_pkt) |-> (in_word.ctrl == CTRL_HDR));

endmodule

`default_nettype wire

//--- src/np_core.sv
//==========================================================================
// four lane packet core, classifier to lane buffers to output arbiter
// register bus is passed through unchanged, filter only listens to it
//==========================================================================
`default_nettype none

module np_core (
    input  logic                   clk,
    input  logic                   reset,
    input  np_types_pkg::np_word_t in_word,
    input  logic                   in_wr,
    output logic                   in_rdy,
    output np_types_pkg::np_word_t out_word,
    output logic                   out_wr,
    input  logic                   out_rdy,
    input  np_reg_pkg::reg_bus_t   reg_in,
    output np_reg_pkg::reg_bus_t   reg_out
);
    import np_types_pkg::*;

    // filter lookup
    logic [31:0]          lookup_ip;
    logic                 match;

    // lane side
    logic [FREE_W-1:0]    free_words [NUM_LANES];
    lane_wr_t             lane_wr [NUM_LANES];
    np_word_t             head_word [NUM_LANES];
    logic [NUM_LANES-1:0] pkt_avail;
    logic [NUM_LANES-1:0] lane_rd;

    // bus pass-through, no latency
    assign reg_out = reg_in;

    dest_ip_filter u_filter (
        .clk       (clk),
        .reset     (reset),
        .reg_in    (reg_in),
        .lookup_ip (lookup_ip),
        .match     (match)
    );

    flow_classifier u_classifier (
        .clk        (clk),
        .reset      (reset),
        .in_word    (in_word),
        .in_wr      (in_wr),
        .in_rdy     (in_rdy),
        .lookup_ip  (lookup_ip),
        .match      (match),
        .free_words (free_words),
        .lane_wr    (lane_wr)
    );

    // identical lanes
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        ppu_packet_buffer u_lane (
            .clk        (clk),
            .reset      (reset),
            .wr_in      (lane_wr[g]),
            .free_words (free_words[g]),
            .head_word  (head_word[g]),
            .pkt_avail  (pkt_avail[g]),
            .rd         (lane_rd[g])
        );
    end

    out_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .head_word (head_word),
        .pkt_avail (pkt_avail),
        .rd        (lane_rd),
        .out_word  (out_word),
        .out_wr    (out_wr),
        .out_rdy   (out_rdy)
    );

endmodule

`default_nettype wire

//--- src/np_reg_pkg.sv
//==========================================================================
// register bus fields and the destination filter address window
// filter window is write only, reads fall through to other blocks
//==========================================================================
`default_nettype none

package np_reg_pkg;

    // bus widths
    localparam int REG_ADDR_WIDTH = 23;
    localparam int REG_DATA_WIDTH = 32;
    localparam int REG_SRC_WIDTH  = 2;

    // filter entries at FILTER_BASE + 0 .. FILTER_ENTRIES-1
    localparam logic [REG_ADDR_WIDTH-1:0] FILTER_BASE = 23'h400000;
    localparam int FILTER_ENTRIES = 16;

    typedef struct packed {
        logic                      req;
        logic                      ack;
        // high for read, low for write
        logic                      rd_wr_l;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [REG_DATA_WIDTH-1:0] data;
        logic [REG_SRC_WIDTH-1:0]  src;
    } reg_bus_t;

endpackage

`default_nettype wire

//--- src/np_types_pkg.sv
//==========================================================================
// datapath words, lane write bundle and small framing helpers
// the round-robin helper assumes NUM_LANES is a power of two
//==========================================================================
`default_nettype none

package np_types_pkg;

    // datapath widths
    localparam int DATA_WIDTH = 64;
    localparam int CTRL_WIDTH = 8;

    // lane layout
    localparam int NUM_LANES  = 4;
    localparam int LANE_W     = 2;
    localparam int LANE_DEPTH = 32;
    // free count must be able to hold LANE_DEPTH itself
    localparam int FREE_W     = $clog2(LANE_DEPTH + 1);

    // packet framing
    localparam int MAX_PKT_WORDS = 16;
    localparam int MIN_PKT_WORDS = 4;
    localparam logic [CTRL_WIDTH-1:0] CTRL_HDR = 8'hFF;
    // destination ip sits in the low half of this word
    localparam int DIP_WORD = 3;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [CTRL_WIDTH-1:0] ctrl;
    } np_word_t;

    // one write into a lane buffer
    typedef struct packed {
        np_word_t word;
        logic     wr;
        logic     commit;
        logic     discard;
    } lane_wr_t;

    // last word of a packet
    function automatic logic is_eop(input logic [CTRL_WIDTH-1:0] ctrl);
        return (ctrl != '0) && (ctrl != CTRL_HDR);
    endfunction

    // first requesting lane after last, last itself has lowest priority
    function automatic logic [LANE_W-1:0] rr_next(input logic [NUM_LANES-1:0] req,
                                                  input logic [LANE_W-1:0]    last);
        logic [LANE_W-1:0] cand;
        logic [LANE_W-1:0] pick;
        pick = last;
        // walk from the far end so the nearest candidate wins
        for (int i = NUM_LANES; i >= 1; i--) begin
            cand = last + LANE_W'(i);
            if (req[cand]) begin
                pick = cand;
            end
        end
        return pick;
    endfunction

endpackage

`default_nettype wire

//--- src/out_arbiter.sv
//==========================================================================
// drains whole packets from the lanes round robin onto the output port
// one idle cycle between packets while the next lane is chosen
//==========================================================================
`default_nettype none

module out_arbiter (
    input  logic                               clk,
    input  logic                               reset,
    input  np_types_pkg::np_word_t             head_word [np_types_pkg::NUM_LANES],
    input  logic [np_types_pkg::NUM_LANES-1:0] pkt_avail,
    output logic [np_types_pkg::NUM_LANES-1:0] rd,
    output np_types_pkg::np_word_t             out_word,
    output logic                               out_wr,
    input  logic                               out_rdy
);
    import np_types_pkg::*;

    logic              busy;
    // granted lane, also the last one served
    logic [LANE_W-1:0] grant;

    // word goes out in the cycle of its rd pulse
    assign out_word = head_word[grant];
    assign out_wr   = busy && out_rdy;

    always_comb begin
        rd        = '0;
        rd[grant] = out_wr;
    end

    //======================================================================
    // grant and release
    //======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            grant <= LANE_W'(NUM_LANES - 1);
        end else if (!busy) begin
            if (|pkt_avail) begin
                busy  <= 1'b1;
                grant <= rr_next(pkt_avail, grant);
            end
        end else if (out_wr && is_eop(out_word.ctrl)) begin
            // end of packet frees the port
            busy <= 1'b0;
        end
    end

    // lane keeps its packet until the last word is gone
    a_grant_has_pkt: assert property (@(posedge clk) disable iff (reset)
        busy |-> pkt_avail[grant]);

endmodule

`default_nettype wire

//--- src/ppu_packet_buffer.sv
//==========================================================================
// one lane of store and forward packet memory, LANE_DEPTH words
// words of an open packet are invisible until commit, discard drops them
//==========================================================================
`default_nettype none

module ppu_packet_buffer (
    input  logic                            clk,
    input  logic                            reset,
    input  np_types_pkg::lane_wr_t          wr_in,
    output logic [np_types_pkg::FREE_W-1:0] free_words,
    output np_types_pkg::np_word_t          head_word,
    output logic                            pkt_avail,
    input  logic                            rd
);
    import np_types_pkg::*;

    localparam int PTR_W = $clog2(LANE_DEPTH);
    // worst case count of stored minimum size packets
    localparam int PKT_W = $clog2(LANE_DEPTH / MIN_PKT_WORDS + 1);

    np_word_t         mem [LANE_DEPTH];

    // pointers carry one wrap bit
    logic [PTR_W:0]   spec_ptr;
    logic [PTR_W:0]   com_ptr;
    logic [PTR_W:0]   rd_ptr;
    logic [PKT_W-1:0] pkt_cnt;
    logic             pkt_in;
    logic             pkt_out;

    assign pkt_in     = wr_in.wr && wr_in.commit;
    assign pkt_out    = rd && is_eop(head_word.ctrl);
    assign head_word  = mem[rd_ptr[PTR_W-1:0]];
    assign pkt_avail  = (pkt_cnt != '0);
    // open packet words already count as used
    assign free_words = FREE_W'(LANE_DEPTH) - FREE_W'(spec_ptr - rd_ptr);

    //======================================================================
    // pointers and packet count
    //======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            spec_ptr <= '0;
            com_ptr  <= '0;
            rd_ptr   <= '0;
            pkt_cnt  <= '0;
        end else begin
            if (wr_in.wr) begin
                if (wr_in.discard) begin
                    // roll back to last committed packet
                    spec_ptr <= com_ptr;
                end else begin
                    spec_ptr <= spec_ptr + 1'b1;
                    if (wr_in.commit) begin
                        com_ptr <= spec_ptr + 1'b1;
                    end
                end
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            pkt_cnt <= pkt_cnt + PKT_W'(pkt_in) - PKT_W'(pkt_out);
        end
    end

    // word storage
    always_ff @(posedge clk) begin
        if (wr_in.wr && !wr_in.discard) begin
            mem[spec_ptr[PTR_W-1:0]] <= wr_in.word;
        end
    end

    // classifier reserved room before writing
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (wr_in.wr && !wr_in.discard) |-> (free_words != '0));

    // arbiter only reads committed packets
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        rd |-> pkt_avail);

endmodule

`default_nettype wire

//--- verification/np_core_tb.sv
//==========================================================================
// directed testbench for np_core with LFSR driven packet lengths and data
// word 1 carries a scoreboard tag which limits a run to 64 packets
//==========================================================================
`default_nettype none

module np_core_tb;
    import np_types_pkg::*;
    import np_reg_pkg::*;

    localparam int NUM_TAGS   = 64;
    // total packets over all tests sizes the watchdog
    localparam int TOTAL_PKTS = 31;
    localparam int CLK_PERIOD = 10;
    localparam logic [31:0] BLOCK_IP = 32'hc0a8_0a05;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    np_word_t    in_word;
    logic        in_wr;
    logic        in_rdy;
    np_word_t    out_word;
    logic        out_wr;
    logic        out_rdy;
    reg_bus_t    reg_in;
    reg_bus_t    reg_out;

    // scoreboard indexed by tag
    np_word_t    exp_words [NUM_TAGS][MAX_PKT_WORDS];
    int          exp_len   [NUM_TAGS];
    bit          exp_live  [NUM_TAGS];
    int          pending = 0;
    int          next_tag = 0;
    // monitor side
    np_word_t    got_words [MAX_PKT_WORDS];
    int          got_len = 0;
    // sender side
    np_word_t    pkt_buf [MAX_PKT_WORDS];
    bit          stalled = 1'b0;
    logic [31:0] lfsr_state = 32'h6dc01545;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    np_core DUT (
        .clk      (clk),
        .reset    (reset),
        .in_word  (in_word),
        .in_wr    (in_wr),
        .in_rdy   (in_rdy),
        .out_word (out_word),
        .out_wr   (out_wr),
        .out_rdy  (out_rdy),
        .reg_in   (reg_in),
        .reg_out  (reg_out)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //======================================================================
    // LFSR random source with taps 32 22 2 1
    //======================================================================
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic int rand_len();
        return MIN_PKT_WORDS + int'(rand_bits(4) % (MAX_PKT_WORDS - MIN_PKT_WORDS + 1));
    endfunction

    //======================================================================
    // compare tasks
    //======================================================================
    task automatic compare_word(input np_word_t got, input np_word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %h/%h expected %h/%h", $time, what,
                     got.data, got.ctrl, exp.data, exp.ctrl);
            errors++;
        end
    endtask

    task automatic compare_reg(input reg_bus_t got, input reg_bus_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    //======================================================================
    // output monitor
    //======================================================================
    task automatic check_packet();
        int tag;
        tag = (got_len > 1) ? int'(got_words[1].data[31:0]) : -1;
        if (got_len > MAX_PKT_WORDS || tag < 0 || tag >= NUM_TAGS || !exp_live[tag]) begin
            $display("unexpected packet of %0d words left the DUT at time %0t", got_len, $time);
            errors++;
        end else begin
            checks++;
            if (got_len != exp_len[tag]) begin
                $display("[ERROR] %0t: packet %0d has %0d words, expected %0d", $time, tag,
                         got_len, exp_len[tag]);
                errors++;
            end else begin
                for (int i = 0; i < got_len; i++) begin
                    compare_word(got_words[i], exp_words[tag][i], "output word");
                end
            end
            exp_live[tag] = 1'b0;
            pending--;
        end
    endtask

    // sampled on negedge where outputs have settled
    always @(negedge clk) begin
        if (!reset) begin
            if (out_wr && !out_rdy) begin
                $display("out_wr asserted while out_rdy was low at time %0t", $time);
                errors++;
            end
            if (got_len != 0 && out_rdy && !out_wr) begin
                $display("gap inside an output packet at time %0t", $time);
                errors++;
            end
            if (out_wr) begin
                if (got_len < MAX_PKT_WORDS) begin
                    got_words[got_len] = out_word;
                end
                got_len++;
                // end of packet
                if (out_word.ctrl != 8'h00 && out_word.ctrl != CTRL_HDR) begin
                    check_packet();
                    got_len = 0;
                end
            end
        end
    end

    //======================================================================
    // stimulus helpers
    //======================================================================
    task automatic drive_pkt(input int len);
        // header waits for in_rdy with in_wr low
        // remaining words stream back to back
        @(negedge clk);
        while (!in_rdy) begin
            stalled = 1'b1;
            @(negedge clk);
        end
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            in_word <= pkt_buf[i];
            in_wr   <= 1'b1;
        end
        @(posedge clk);
        in_wr <= 1'b0;
    endtask

    task automatic send_pkt(input int len, input logic [31:0] ip, input bit dropped);
        int         tag;
        logic [7:0] last_ctrl;
        tag = next_tag;
        next_tag++;
        for (int i = 0; i < len; i++) begin
            pkt_buf[i].data = rand_bits(64);
            pkt_buf[i].ctrl = 8'h00;
        end
        pkt_buf[0].ctrl = CTRL_HDR;
        pkt_buf[1].data[31:0] = 32'(tag);
        pkt_buf[DIP_WORD].data[31:0] = ip;
        // any nonzero non-header value ends a packet
        last_ctrl = 8'(rand_bits(8));
        if (last_ctrl == 8'h00 || last_ctrl == CTRL_HDR) begin
            last_ctrl = 8'h01;
        end
        pkt_buf[len-1].ctrl = last_ctrl;
        if (!dropped) begin
            for (int i = 0; i < len; i++) begin
                exp_words[tag][i] = pkt_buf[i];
            end
            exp_len[tag]  = len;
            exp_live[tag] = 1'b1;
            pending++;
        end
        drive_pkt(len);
    endtask

    task automatic write_filter(input int idx, input logic [31:0] ip);
        reg_bus_t v;
        v         = '0;
        v.req     = 1'b1;
        v.rd_wr_l = 1'b0;
        v.addr    = FILTER_BASE + REG_ADDR_WIDTH'(idx);
        v.data    = ip;
        @(posedge clk);
        reg_in <= v;
        @(posedge clk);
        reg_in <= '0;
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (pending != 0 && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (pending != 0) begin
            $display("%0d expected packets never left the DUT by time %0t", pending, $time);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("test %-14s %s, %0d new errors", name,
                 (errors == err_before) ? "ok" : "with errors", errors - err_before);
    endtask

    //======================================================================
    // directed tests
    //======================================================================
    task automatic reg_passthrough();
        int          err_before;
        logic [63:0] r;
        reg_bus_t    v;
        err_before = errors;
        for (int i = 0; i < 8; i++) begin
            r = rand_bits($bits(reg_bus_t));
            v = r[$bits(reg_bus_t)-1:0];
            // reads only so the filter table stays untouched
            v.rd_wr_l = 1'b1;
            @(posedge clk);
            reg_in <= v;
            @(negedge clk);
            compare_reg(reg_out, v, "reg_out");
        end
        @(posedge clk);
        reg_in <= '0;
        finish_test("reg_passthru", err_before);
    endtask

    task automatic single_packet();
        int err_before;
        err_before = errors;
        @(negedge clk);
        checks++;
        if (!in_rdy || out_wr) begin
            $display("[ERROR] %0t: idle state wrong after reset, in_rdy %b out_wr %b",
                     $time, in_rdy, out_wr);
            errors++;
        end
        send_pkt(6, 32'(rand_bits(32)), 1'b0);
        wait_drain(400);
        finish_test("single_packet", err_before);
    endtask

    task automatic packet_burst();
        int err_before;
        err_before = errors;
        for (int i = 0; i < 12; i++) begin
            send_pkt(rand_len(), 32'(rand_bits(32)), 1'b0);
        end
        wait_drain(2000);
        finish_test("burst", err_before);
    endtask

    task automatic filter_drop();
        int err_before;
        err_before = errors;
        write_filter(5, BLOCK_IP);
        for (int i = 0; i < 6; i++) begin
            if (i % 2 == 0) begin
                send_pkt(rand_len(), BLOCK_IP, 1'b1);
            end else begin
                send_pkt(rand_len(), 32'(rand_bits(32)), 1'b0);
            end
        end
        wait_drain(2000);
        // a wrongly committed packet would show up in this window
        repeat (100) @(negedge clk);
        write_filter(5, 32'h0);
        send_pkt(rand_len(), BLOCK_IP, 1'b0);
        send_pkt(rand_len(), BLOCK_IP, 1'b0);
        wait_drain(1000);
        finish_test("filter", err_before);
    endtask

    task automatic output_stall();
        int err_before;
        int n;
        err_before = errors;
        stalled = 1'b0;
        @(posedge clk);
        out_rdy <= 1'b0;
        fork
            begin
                // full size packets of which two fit per lane
                for (int i = 0; i < 10; i++) begin
                    send_pkt(MAX_PKT_WORDS, 32'(rand_bits(32)), 1'b0);
                end
            end
            begin
                n = 0;
                while (!stalled && n < 1000) begin
                    @(negedge clk);
                    n++;
                end
                if (!stalled) begin
                    $display("in_rdy never fell while out_rdy was held low");
                    errors++;
                end
                @(posedge clk);
                out_rdy <= 1'b1;
            end
        join
        wait_drain(2000);
        finish_test("backpressure", err_before);
    endtask

    //======================================================================
    // main sequence
    //======================================================================
    initial begin
        in_word = '0;
        in_wr   = 1'b0;
        out_rdy = 1'b1;
        reg_in  = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        reg_passthrough();
        single_packet();
        packet_burst();
        filter_drop();
        output_stall();
        if (pending != 0) begin
            $display("scoreboard still holds %0d packets at the end", pending);
            errors++;
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog allows 200 cycles per packet plus 1000
    initial begin
        #((TOTAL_PKTS * 200 + 1000) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
